// ==== run.sh ====
#!/bin/sh
# build and run the accumulator unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_acc_unit -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_acc_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1

// ==== sim.f ====
src/acc_pkg.sv
src/acc_alu.sv
src/acc_decode.sv
src/acc_execute.sv
src/acc_unit.sv
tests/tb_acc_unit.sv

// ==== src/acc_alu.sv ====
/*
 * Combinational 8080 ALU: adder, logic ops, rotates and decimal adjust.
 * Subtraction adds the complemented operand, so carry out is inverted to give borrow.
 * Flags an operation does not touch pass through from flags_in.
 */
`timescale 1ns/1ps
`default_nettype none

module acc_alu
(
	input acc_pkg::alu_op_t op,
	input logic [acc_pkg::data_w-1:0] operand,
	input logic [acc_pkg::data_w-1:0] acc_in,
	input acc_pkg::flags_t flags_in,
	output logic [acc_pkg::data_w-1:0] result,
	output acc_pkg::flags_t flags_out
);

	logic [acc_pkg::data_w-1:0] add_b;
	logic [acc_pkg::data_w-1:0] daa_b;
	logic add_cin;
	logic [acc_pkg::data_w:0] sum;
	logic [4:0] half;
	logic is_sub;
	logic lo_adj;
	logic hi_adj;
	logic set_szp;

	assign is_sub = (op == acc_pkg::op_sub) || (op == acc_pkg::op_sbb) ||
		(op == acc_pkg::op_cmp);

	// decimal adjust decisions are taken on the accumulator before correction
	assign lo_adj = (acc_in[3:0] > acc_pkg::bcd_max) | flags_in.aux_carry;
	assign hi_adj = (acc_in[7:4] > acc_pkg::bcd_max) |
		((acc_in[7:4] == acc_pkg::bcd_max) & (acc_in[3:0] > acc_pkg::bcd_max)) |
		flags_in.carry;
	assign daa_b = {hi_adj ? acc_pkg::daa_corr : 4'h0, lo_adj ? acc_pkg::daa_corr : 4'h0};

	always_comb
	begin
		case (op)
			acc_pkg::op_adc: add_cin = flags_in.carry;
			acc_pkg::op_sbb: add_cin = ~flags_in.carry;
			acc_pkg::op_sub, acc_pkg::op_cmp: add_cin = 1'b1;
			default: add_cin = 1'b0;
		endcase
	end

	// one adder serves add, subtract, compare and the DAA correction
	assign add_b = is_sub ? ~operand : (op == acc_pkg::op_daa) ? daa_b : operand;
	assign sum = {1'b0, acc_in} + {1'b0, add_b} + {{acc_pkg::data_w{1'b0}}, add_cin};
	assign half = {1'b0, acc_in[3:0]} + {1'b0, add_b[3:0]} + {4'd0, add_cin};

	always_comb
	begin
		result = acc_in;
		flags_out = flags_in;
		set_szp = 1'b0;
		case (op)
			acc_pkg::op_add, acc_pkg::op_adc:
			begin
				result = sum[7:0];
				flags_out.carry = sum[8];
				flags_out.aux_carry = half[4];
				set_szp = 1'b1;
			end
			acc_pkg::op_sub, acc_pkg::op_sbb, acc_pkg::op_cmp:
			begin
				// carry out of a complement add means no borrow
				result = sum[7:0];
				flags_out.carry = ~sum[8];
				flags_out.aux_carry = half[4];
				set_szp = 1'b1;
			end
			acc_pkg::op_ana:
			begin
				result = acc_in & operand;
				flags_out.carry = 1'b0;
				flags_out.aux_carry = acc_in[3] | operand[3];
				set_szp = 1'b1;
			end
			acc_pkg::op_xra, acc_pkg::op_ora:
			begin
				result = (op == acc_pkg::op_xra) ? (acc_in ^ operand) : (acc_in | operand);
				flags_out.carry = 1'b0;
				flags_out.aux_carry = 1'b0;
				set_szp = 1'b1;
			end
			acc_pkg::op_rlc:
			begin
				result = {acc_in[6:0], acc_in[7]};
				flags_out.carry = acc_in[7];
			end
			acc_pkg::op_rrc:
			begin
				result = {acc_in[0], acc_in[7:1]};
				flags_out.carry = acc_in[0];
			end
			acc_pkg::op_ral:
			begin
				result = {acc_in[6:0], flags_in.carry};
				flags_out.carry = acc_in[7];
			end
			acc_pkg::op_rar:
			begin
				result = {flags_in.carry, acc_in[7:1]};
				flags_out.carry = acc_in[0];
			end
			acc_pkg::op_daa:
			begin
				// carry is only ever set by DAA, never cleared
				result = sum[7:0];
				flags_out.carry = flags_in.carry | hi_adj;
				flags_out.aux_carry = half[4];
				set_szp = 1'b1;
			end
			acc_pkg::op_cma: result = ~acc_in;
			acc_pkg::op_stc: flags_out.carry = 1'b1;
			acc_pkg::op_cmc: flags_out.carry = ~flags_in.carry;
			acc_pkg::op_mvi: result = operand;
			default: result = acc_in;
		endcase
		if (set_szp)
		begin
			flags_out.sign = result[7];
			flags_out.zero = ~(|result);
			// 8080 parity flag is set for even parity
			flags_out.parity = ~(^result);
		end
	end

endmodule

`default_nettype wire

// ==== src/acc_decode.sv ====
/*
 * First pipeline stage. Classifies the opcode byte and registers it with the operand.
 * Any opcode outside the ALU, accumulator and MVI A groups becomes op_nop.
 */
`timescale 1ns/1ps
`default_nettype none

module acc_decode
(
	input logic clk,
	input logic reset,
	input logic op_valid,
	input logic [acc_pkg::data_w-1:0] opcode,
	input logic [acc_pkg::data_w-1:0] operand,
	output acc_pkg::dec_stage_t dec
);

	acc_pkg::alu_op_t next_op;
	acc_pkg::alu_op_t op_q;
	logic [acc_pkg::data_w-1:0] operand_q;
	logic valid_q;
	logic is_alu_grp;
	logic is_acc_grp;

	// 10xxxsss register form, 11xxx110 immediate form
	assign is_alu_grp = (opcode[7:6] == acc_pkg::grp_reg) ||
		(opcode[7:6] == acc_pkg::grp_imm && opcode[2:0] == acc_pkg::src_imm);
	assign is_acc_grp = (opcode[7:6] == acc_pkg::grp_acc) && (opcode[2:0] == acc_pkg::src_acc);

	always_comb
	begin
		next_op = acc_pkg::op_nop;
		if (opcode == acc_pkg::op_mvi_a)
			next_op = acc_pkg::op_mvi;
		else if (is_alu_grp)
		begin
			case (opcode[5:3])
				3'b000: next_op = acc_pkg::op_add;
				3'b001: next_op = acc_pkg::op_adc;
				3'b010: next_op = acc_pkg::op_sub;
				3'b011: next_op = acc_pkg::op_sbb;
				3'b100: next_op = acc_pkg::op_ana;
				3'b101: next_op = acc_pkg::op_xra;
				3'b110: next_op = acc_pkg::op_ora;
				default: next_op = acc_pkg::op_cmp;
			endcase
		end
		else if (is_acc_grp)
		begin
			case (opcode[5:3])
				3'b000: next_op = acc_pkg::op_rlc;
				3'b001: next_op = acc_pkg::op_rrc;
				3'b010: next_op = acc_pkg::op_ral;
				3'b011: next_op = acc_pkg::op_rar;
				3'b100: next_op = acc_pkg::op_daa;
				3'b101: next_op = acc_pkg::op_cma;
				3'b110: next_op = acc_pkg::op_stc;
				default: next_op = acc_pkg::op_cmc;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= op_valid;
	end

	// payload only moves with a strobe
	always_ff @(posedge clk)
	begin
		if (op_valid)
		begin
			op_q <= next_op;
			operand_q <= operand;
		end
	end

	assign dec = '{valid: valid_q, op: op_q, operand: operand_q};

	// a strobe carries known bytes because an X opcode would decode as op_nop
	assert property (@(posedge clk) disable iff (reset)
		op_valid |-> !$isunknown({opcode, operand}));

endmodule

`default_nettype wire

// ==== src/acc_execute.sv ====
/*
 * Second pipeline stage. Holds the accumulator and flags and applies the ALU result.
 * The ALU reads the registered accumulator, so back-to-back operations chain without stall.
 * No back-pressure; result_valid is a one-cycle strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module acc_execute
(
	input logic clk,
	input logic reset,
	input acc_pkg::dec_stage_t dec,
	output logic result_valid,
	output logic [acc_pkg::data_w-1:0] acc,
	output acc_pkg::flags_t flags
);

	logic [acc_pkg::data_w-1:0] alu_result;
	acc_pkg::flags_t alu_flags;
	logic acc_we;

	acc_alu u_alu
	(
		.op(dec.op),
		.operand(dec.operand),
		.acc_in(acc),
		.flags_in(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	// compare and undecoded opcodes keep the accumulator
	assign acc_we = dec.valid && (dec.op != acc_pkg::op_cmp) && (dec.op != acc_pkg::op_nop);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			acc <= '0;
			flags <= '0;
		end
		else
		begin
			result_valid <= dec.valid;
			if (acc_we)
				acc <= alu_result;
			if (dec.valid)
				flags <= alu_flags;
		end
	end

	// a result strobe always shows a known accumulator and flags
	assert property (@(posedge clk) disable iff (reset)
		result_valid |-> !$isunknown({acc, flags}));

endmodule

`default_nettype wire

// ==== src/acc_pkg.sv ====
/*
 * Shared types for the 8080 accumulator unit.
 * Widths are fixed to the 8080 byte; the opcode patterns follow the 8080 map.
 */
`default_nettype none

package acc_pkg;

	// data byte width
	localparam int data_w = 8;

	// bits 7:6 of the register, immediate and accumulator groups
	localparam logic [1:0] grp_reg = 2'b10;
	localparam logic [1:0] grp_imm = 2'b11;
	localparam logic [1:0] grp_acc = 2'b00;

	// bits 2:0 that complete the immediate and accumulator groups
	localparam logic [2:0] src_imm = 3'b110;
	localparam logic [2:0] src_acc = 3'b111;

	// MVI A,d8
	localparam logic [data_w-1:0] op_mvi_a = 8'h3E;

	// decimal adjust limits
	localparam logic [3:0] bcd_max = 4'd9;
	localparam logic [3:0] daa_corr = 4'h6;

	typedef enum logic [4:0]
	{
		op_nop,
		op_add,
		op_adc,
		op_sub,
		op_sbb,
		op_ana,
		op_xra,
		op_ora,
		op_cmp,
		op_rlc,
		op_rrc,
		op_ral,
		op_rar,
		op_daa,
		op_cma,
		op_stc,
		op_cmc,
		op_mvi
	} alu_op_t;

	// status flags, same set as the 8080 PSW
	typedef struct packed
	{
		logic sign;
		logic zero;
		logic aux_carry;
		logic parity;
		logic carry;
	} flags_t;

	// decode to execute stage register
	typedef struct packed
	{
		logic valid;
		alu_op_t op;
		logic [data_w-1:0] operand;
	} dec_stage_t;

endpackage

`default_nettype wire

// ==== src/acc_unit.sv ====
/*
 * 8080 accumulator unit top. Results appear two cycles after the op_valid strobe.
 * Up to two operations are in flight; nothing stalls.
 */
`timescale 1ns/1ps
`default_nettype none

module acc_unit
(
	input logic clk,
	input logic reset,
	input logic op_valid,
	input logic [acc_pkg::data_w-1:0] opcode,
	input logic [acc_pkg::data_w-1:0] operand,
	output logic result_valid,
	output logic [acc_pkg::data_w-1:0] acc,
	output acc_pkg::flags_t flags
);

	acc_pkg::dec_stage_t dec;

	acc_decode u_decode
	(
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.opcode(opcode),
		.operand(operand),
		.dec(dec)
	);

	acc_execute u_execute
	(
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.result_valid(result_valid),
		.acc(acc),
		.flags(flags)
	);

endmodule

`default_nettype wire

// ==== tests/tb_acc_unit.sv ====
/*
 * Directed testbench for the accumulator unit with an 8080 reference model.
 * Results are checked on falling edges and must arrive exactly 2 cycles after each strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_acc_unit;

	typedef struct packed
	{
		logic [31:0] cyc;
		logic [7:0] acc;
		acc_pkg::flags_t flags;
	} expect_t;

	// 64 operations at up to 2 cycles each, plus reset and idle cycles
	localparam int op_count = 64;
	localparam int test_cycles = op_count * 2 + 16;
	localparam int timeout_cycles = 2 * test_cycles;

	logic clk;
	logic reset;
	logic op_valid;
	logic [7:0] opcode;
	logic [7:0] operand;
	logic result_valid;
	logic [7:0] acc;
	acc_pkg::flags_t flags;

	int cyc = 0;
	int errors = 0;
	logic [15:0] lfsr_state = 16'd16;
	logic [7:0] exp_acc;
	acc_pkg::flags_t exp_flags;
	expect_t exp_q[$];

	acc_unit UUT
	(
		.clk(clk),
		.reset(reset),
		.op_valid(op_valid),
		.opcode(opcode),
		.operand(operand),
		.result_valid(result_valid),
		.acc(acc),
		.flags(flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc == timeout_cycles)
		begin
			$display("timeout: results did not arrive within %0d cycles", timeout_cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		begin
			for (int i = 0; i < 8; i++)
			begin
				lfsr_state = lfsr_next(lfsr_state);
				b[i] = lfsr_state[0];
			end
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input string name, input acc_pkg::flags_t got,
		input acc_pkg::flags_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s got %b expected %b (s z ac p cy)", $time, name, got, exp);
			errors++;
		end
	endtask

	// 8080 rules, applied to the model state in issue order
	task automatic model_apply(input acc_pkg::alu_op_t op, input logic [7:0] d);
		logic [8:0] wide;
		logic [4:0] low;
		logic cin;
		logic lo;
		logic hi;
		logic szp;
		logic [7:0] r;
		acc_pkg::flags_t f;
		begin
			r = exp_acc;
			f = exp_flags;
			szp = 1'b0;
			case (op)
				acc_pkg::op_add, acc_pkg::op_adc:
				begin
					cin = (op == acc_pkg::op_adc) ? f.carry : 1'b0;
					wide = {1'b0, exp_acc} + {1'b0, d} + {8'd0, cin};
					low = {1'b0, exp_acc[3:0]} + {1'b0, d[3:0]} + {4'd0, cin};
					r = wide[7:0];
					f.carry = wide[8];
					f.aux_carry = low[4];
					szp = 1'b1;
				end
				acc_pkg::op_sub, acc_pkg::op_sbb, acc_pkg::op_cmp:
				begin
					// borrow in from carry for SBB
					cin = (op == acc_pkg::op_sbb) ? f.carry : 1'b0;
					wide = {1'b0, exp_acc} - {1'b0, d} - {8'd0, cin};
					low = {1'b0, exp_acc[3:0]} + {1'b0, ~d[3:0]} + {4'd0, ~cin};
					r = wide[7:0];
					f.carry = wide[8];
					f.aux_carry = low[4];
					szp = 1'b1;
				end
				acc_pkg::op_ana:
				begin
					r = exp_acc & d;
					f.carry = 1'b0;
					f.aux_carry = exp_acc[3] | d[3];
					szp = 1'b1;
				end
				acc_pkg::op_xra, acc_pkg::op_ora:
				begin
					r = (op == acc_pkg::op_xra) ? (exp_acc ^ d) : (exp_acc | d);
					f.carry = 1'b0;
					f.aux_carry = 1'b0;
					szp = 1'b1;
				end
				acc_pkg::op_rlc:
				begin
					r = {exp_acc[6:0], exp_acc[7]};
					f.carry = exp_acc[7];
				end
				acc_pkg::op_rrc:
				begin
					r = {exp_acc[0], exp_acc[7:1]};
					f.carry = exp_acc[0];
				end
				acc_pkg::op_ral:
				begin
					r = {exp_acc[6:0], f.carry};
					f.carry = exp_acc[7];
				end
				acc_pkg::op_rar:
				begin
					r = {f.carry, exp_acc[7:1]};
					f.carry = exp_acc[0];
				end
				acc_pkg::op_daa:
				begin
					// low digit first, then the high digit of the adjusted value
					lo = (exp_acc[3:0] > 4'd9) || f.aux_carry;
					low = {1'b0, exp_acc[3:0]} + (lo ? 5'd6 : 5'd0);
					wide = {1'b0, exp_acc} + (lo ? 9'h006 : 9'h000);
					hi = (wide[7:4] > 4'd9) || f.carry || wide[8];
					r = wide[7:0] + (hi ? 8'h60 : 8'h00);
					f.carry = f.carry | hi;
					f.aux_carry = low[4];
					szp = 1'b1;
				end
				acc_pkg::op_cma: r = ~exp_acc;
				acc_pkg::op_stc: f.carry = 1'b1;
				acc_pkg::op_cmc: f.carry = ~f.carry;
				acc_pkg::op_mvi: r = d;
				default: r = exp_acc;
			endcase
			if (szp)
			begin
				f.sign = r[7];
				f.zero = (r == 8'h00);
				f.parity = ~(^r);
			end
			exp_flags = f;
			if (op != acc_pkg::op_cmp)
				exp_acc = r;
		end
	endtask

	// called once per falling edge; a result is due 2 cycles after its strobe
	task automatic sample_results();
		expect_t e;
		logic due;
		begin
			due = (exp_q.size() != 0) && (cyc == exp_q[0].cyc + 32'd2);
			check_bit("result_valid", result_valid, due);
			if (due)
			begin
				e = exp_q.pop_front();
				check_byte("acc", acc, e.acc);
				check_flags("flags", flags, e.flags);
			end
		end
	endtask

	// leaves op_valid high so consecutive calls give back-to-back strobes
	task automatic issue(input logic [7:0] opc, input acc_pkg::alu_op_t op, input logic [7:0] d);
		expect_t entry;
		begin
			op_valid = 1'b1;
			opcode = opc;
			operand = d;
			model_apply(op, d);
			entry.cyc = cyc;
			entry.acc = exp_acc;
			entry.flags = exp_flags;
			exp_q.push_back(entry);
			@(negedge clk);
			sample_results();
		end
	endtask

	task automatic drain();
		begin
			op_valid = 1'b0;
			while (exp_q.size() != 0)
			begin
				@(negedge clk);
				sample_results();
			end
		end
	endtask

	// operation selected by bits 5:3 of the register and immediate forms
	function automatic acc_pkg::alu_op_t group_op(input logic [2:0] k);
		case (k)
			3'd0: return acc_pkg::op_add;
			3'd1: return acc_pkg::op_adc;
			3'd2: return acc_pkg::op_sub;
			3'd3: return acc_pkg::op_sbb;
			3'd4: return acc_pkg::op_ana;
			3'd5: return acc_pkg::op_xra;
			3'd6: return acc_pkg::op_ora;
			default: return acc_pkg::op_cmp;
		endcase
	endfunction

	task automatic reset_state_test();
		begin
			check_byte("acc", acc, 8'h00);
			check_flags("flags", flags, '0);
			repeat (4)
			begin
				@(negedge clk);
				sample_results();
			end
		end
	endtask

	task automatic immediate_ops_test();
		logic [7:0] a;
		logic [7:0] b;
		begin
			for (int k = 0; k < 8; k++)
			begin
				rand_byte(a);
				rand_byte(b);
				issue(acc_pkg::op_mvi_a, acc_pkg::op_mvi, a);
				drain();
				issue({2'b11, k[2:0], 3'b110}, group_op(k[2:0]), b);
				drain();
			end
			check_byte("acc after cmp", acc, a);
		end
	endtask

	task automatic back_to_back_test();
		logic [7:0] b [0:7];
		begin
			for (int i = 0; i < 8; i++)
				rand_byte(b[i]);
			issue(acc_pkg::op_mvi_a, acc_pkg::op_mvi, b[0]);
			issue(8'h80, acc_pkg::op_add, b[1]);
			issue(8'h91, acc_pkg::op_sub, b[2]);
			issue(8'hAA, acc_pkg::op_xra, b[3]);
			issue(8'h8B, acc_pkg::op_adc, b[4]);
			issue(8'hB4, acc_pkg::op_ora, b[5]);
			issue(8'h9D, acc_pkg::op_sbb, b[6]);
			issue(8'hA0, acc_pkg::op_ana, b[7]);
			drain();
		end
	endtask

	task automatic rotate_carry_test();
		logic [7:0] a;
		begin
			for (int v = 0; v < 4; v++)
			begin
				rand_byte(a);
				issue(acc_pkg::op_mvi_a, acc_pkg::op_mvi, a);
				issue(8'h07, acc_pkg::op_rlc, 8'h00);
				issue(8'h0F, acc_pkg::op_rrc, 8'h00);
				issue(8'h17, acc_pkg::op_ral, 8'h00);
				issue(8'h1F, acc_pkg::op_rar, 8'h00);
				drain();
			end
			issue(8'h37, acc_pkg::op_stc, 8'h00);
			issue(8'h3F, acc_pkg::op_cmc, 8'h00);
			issue(8'h2F, acc_pkg::op_cma, 8'h00);
			issue(8'h3F, acc_pkg::op_cmc, 8'h00);
			drain();
		end
	endtask

	task automatic daa_case(input logic [7:0] a, input logic [7:0] b, input logic [7:0] bcd,
		input logic cy);
		begin
			issue(acc_pkg::op_mvi_a, acc_pkg::op_mvi, a);
			issue(8'hC6, acc_pkg::op_add, b);
			issue(8'h27, acc_pkg::op_daa, 8'h00);
			drain();
			check_byte("daa result", acc, bcd);
			check_bit("daa carry", flags.carry, cy);
		end
	endtask

	task automatic undecoded_test();
		logic [7:0] a;
		begin
			rand_byte(a);
			issue(acc_pkg::op_mvi_a, acc_pkg::op_mvi, a);
			drain();
			// NOP, HLT and INR A are outside the kept set
			issue(8'h00, acc_pkg::op_nop, 8'h5A);
			issue(8'h76, acc_pkg::op_nop, 8'h11);
			issue(8'h3C, acc_pkg::op_nop, 8'h22);
			drain();
			check_byte("acc after undecoded", acc, a);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		op_valid = 1'b0;
		opcode = 8'h00;
		operand = 8'h00;
		exp_acc = 8'h00;
		exp_flags = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reset_state_test();
		immediate_ops_test();
		back_to_back_test();
		rotate_carry_test();
		// low digit only, high digit only, both with aux carry, both from carry
		daa_case(8'h15, 8'h27, 8'h42, 1'b0);
		daa_case(8'h52, 8'h61, 8'h13, 1'b1);
		daa_case(8'h48, 8'h59, 8'h07, 1'b1);
		daa_case(8'h99, 8'h99, 8'h98, 1'b1);
		undecoded_test();
		$display("tests run: 6, errors: %0d", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
